//--- test/fetch_golden.dat
// four hex fields per record, a record of kind 0 ends the data
// kind 1 is a program word given as address, word, unused
// kind 2 is a rollback given as cumulative pop count, new pc, unused
// kind 3 is an expected instruction given as npc, inst, target

1 00 40220403 0
1 04 40430404 0
1 08 e4200004 0   // beq, predicted not taken
1 0c 40640405 0
1 10 c3e00004 0   // br to the odd word at 24
1 14 4085040a 0   // shadow of the br
1 20 408604aa 0   // even word skipped by the odd target
1 24 40a70406 0
1 28 40c80407 0
1 2c d3400008 0   // bsr to 50 from slot 1
1 40 4143040b 0
1 44 4164040c 0
1 48 4185040d 0
1 4c 41a6040e 0
1 50 f45ffffe 0   // bne backwards, falls through
1 54 41010409 0
1 58 c3fffff9 0   // br back to 40
1 5c 4122040a 0

2 5 44 0
2 9 0c 0

// from reset
3 04 40220403 04
3 08 40430404 08
3 0c e4200004 0c
3 10 40640405 10
3 14 c3e00004 24
3 28 40a70406 28
3 2c 40c80407 2c
3 30 d3400008 50
3 54 f45ffffe 54
3 58 41010409 58
// after rollback to 44
3 48 4164040c 48
3 4c 4185040d 4c
3 50 41a6040e 50
3 54 f45ffffe 54
3 58 41010409 58
3 5c c3fffff9 40
3 44 4143040b 44
3 48 4164040c 48
// after rollback to 0c
3 10 40640405 10
3 14 c3e00004 24
3 28 40a70406 28
3 2c 40c80407 2c
3 30 d3400008 50
3 54 f45ffffe 54
3 58 41010409 58
3 5c c3fffff9 40

0 0 0 0

//--- verilog.f
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/fetch_predecode.sv
hdl/fetch_buffer.sv
hdl/fetch_frontend.sv
test/fetch_frontend_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module fetch_frontend_tb \
	  -f verilog.f -o fetch_sim
	./obj_dir/fetch_sim | tee $(LOG)
	grep -qx "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/fetch_frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend_tb;

  logic                       clock;
  logic                       rst;
  logic                       en;
  logic [fetch_pkg::xlen-1:0] imem_addr;
  logic [63:0]                imem_data;
  logic                       get_next_inst;
  logic                       rollback_en;
  logic [fetch_pkg::xlen-1:0] rollback_pc;
  fetch_pkg::fb_decoder_out_t fb_decoder_out;
  logic                       inst_out_valid;

  logic [63:0] golden [0:255];                     // four fields per record
  logic [31:0] prog_mem [0:255];                   // first 1 KiB of program space

  logic [fetch_pkg::xlen-1:0] exp_npc[$];
  fetch_pkg::inst_t           exp_inst[$];
  logic [fetch_pkg::xlen-1:0] exp_target[$];
  int                         rb_pops[$];          // cumulative pops before each rollback
  logic [fetch_pkg::xlen-1:0] rb_pc[$];

  int          n_exp;
  int          exp_idx;
  int          pops;
  int          rb_idx;
  int          checks;
  int          errors;
  int          seg;
  int          seg_start;
  int          seg_err;
  logic [31:0] rnd;
  logic        loaded = 1'b0;
  logic        want_pop;
  logic        want_en;
  logic        want_rb;
  logic        check_flush;                        // first cycle after a rollback

  fetch_frontend u_dut (
    .clock          (clock),
    .rst            (rst),
    .en             (en),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .get_next_inst  (get_next_inst),
    .rollback_en    (rollback_en),
    .rollback_pc    (rollback_pc),
    .fb_decoder_out (fb_decoder_out),
    .inst_out_valid (inst_out_valid)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // instruction memory answering in the same cycle
  always_comb begin
    if (imem_addr[63:10] == 54'd0) begin
      imem_data = {prog_mem[{imem_addr[9:3], 1'b1}], prog_mem[{imem_addr[9:3], 1'b0}]};
    end else begin
      imem_data = {2{32'h47ff041f}};               // bis r31,r31,r31
    end
  end

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_entry(
    input int                         slot,
    input logic [fetch_pkg::xlen-1:0] ref_npc,
    input fetch_pkg::inst_t           ref_inst,
    input logic [fetch_pkg::xlen-1:0] ref_target,
    input logic [fetch_pkg::xlen-1:0] npc,
    input fetch_pkg::inst_t           inst,
    input logic [fetch_pkg::xlen-1:0] target
  );
    checks++;
    if (npc !== ref_npc) begin
      $display("Mismatch at %0t: fb_decoder_out.npc[%0d] expected %h, got %h",
               $time, slot, ref_npc, npc);
      errors++;
    end
    if (inst !== ref_inst) begin
      $display("Mismatch at %0t: fb_decoder_out.inst[%0d] expected %h, got %h",
               $time, slot, ref_inst, inst);
      errors++;
    end
    if (target !== ref_target) begin
      $display("Mismatch at %0t: fb_decoder_out.target[%0d] expected %h, got %h",
               $time, slot, ref_target, target);
      errors++;
    end
  endtask

  task automatic check_valid(input string name, input logic ref_bit, input logic act_bit);
    checks++;
    if (act_bit !== ref_bit) begin
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, ref_bit, act_bit);
      errors++;
    end
  endtask

  task automatic compare_slot(
    input int                         slot,
    input logic [fetch_pkg::xlen-1:0] npc,
    input fetch_pkg::inst_t           inst,
    input logic [fetch_pkg::xlen-1:0] target
  );
    if (exp_idx < n_exp) begin
      check_entry(slot, exp_npc[exp_idx], exp_inst[exp_idx], exp_target[exp_idx],
                  npc, inst, target);
    end else begin
      $display("At %0t the DUT delivered more instructions than the golden stream holds",
               $time);
      errors++;
    end
    exp_idx++;
  endtask

  task automatic load_golden();
    int               r;
    fetch_pkg::inst_t word;
    for (r = 0; r < 256; r++) begin
      golden[r]   = 64'd0;
      prog_mem[r] = 32'h47ff041f;                  // no-op outside the program
    end
    $readmemh("test/fetch_golden.dat", golden);
    r = 0;
    while (r < 64 && golden[4*r] != 64'd0) begin
      word = golden[4*r+2][31:0];
      case (golden[4*r])
        64'd1: prog_mem[golden[4*r+1][9:2]] = golden[4*r+2][31:0];
        64'd2: begin
          rb_pops.push_back(int'(golden[4*r+1]));
          rb_pc.push_back(golden[4*r+2]);
        end
        64'd3: begin
          exp_npc.push_back(golden[4*r+1]);
          exp_inst.push_back(word);
          exp_target.push_back(golden[4*r+3]);
        end
        default: begin
          $display("Golden record %0d has an unknown kind %0h", r, golden[4*r]);
          errors++;
        end
      endcase
      r++;
    end
    n_exp = exp_npc.size();
    if (n_exp == 0) begin
      $display("The golden data lists no expected instructions");
      errors++;
    end
  endtask

  task automatic report_segment(input string cause);
    $display("segment %0d (%s): %0d instructions, %0d errors",
             seg, cause, exp_idx - seg_start, errors - seg_err);
    seg++;
    seg_start = exp_idx;
    seg_err   = errors;
  endtask

  initial begin
    rst           <= 1'b1;
    en            <= 1'b1;
    get_next_inst <= 1'b0;
    rollback_en   <= 1'b0;
    rollback_pc   <= '0;
    checks      = 0;
    errors      = 0;
    exp_idx     = 0;
    pops        = 0;
    rb_idx      = 0;
    want_pop    = 1'b0;
    want_en     = 1'b1;
    want_rb     = 1'b0;
    check_flush = 1'b0;
    rnd         = 32'd42043;
    load_golden();
    loaded = 1'b1;

    repeat (3) @(posedge clock);
    rst <= 1'b0;
    @(negedge clock);
    check_valid("inst_out_valid after reset", 1'b0, inst_out_valid);
    $display("reset: %0d errors", errors);
    seg       = 1;
    seg_start = 0;
    seg_err   = errors;

    while (exp_idx < n_exp) begin
      @(posedge clock);
      get_next_inst <= want_pop;
      en            <= want_en;
      rollback_en   <= want_rb;
      if (want_rb) begin
        rollback_pc <= rb_pc[rb_idx];
      end
      @(negedge clock);                            // outputs settled here
      check_valid("imem_addr pair alignment", 1'b1, imem_addr[2:0] == 3'b000);
      if (check_flush) begin
        check_valid("inst_out_valid after rollback", 1'b0, inst_out_valid);
        check_flush = 1'b0;
      end
      if (get_next_inst && en && !rollback_en) begin
        check_valid("inst_out_valid", 1'b1, inst_out_valid);
        check_valid("fb_decoder_out.valid", 1'b1, fb_decoder_out.valid);
        compare_slot(0, fb_decoder_out.npc[0], fb_decoder_out.inst[0], fb_decoder_out.target[0]);
        compare_slot(1, fb_decoder_out.npc[1], fb_decoder_out.inst[1], fb_decoder_out.target[1]);
        pops++;                                    // retires at the next edge
      end
      if (rollback_en) begin
        report_segment("ended by rollback");
        rb_idx++;
        check_flush = 1'b1;
      end
      rnd      = next_rand(rnd);
      want_en  = (rnd[2:0] != 3'd0);
      want_pop = !get_next_inst && !rollback_en && inst_out_valid && rnd[8];
      want_rb  = 1'b0;
      if (!rollback_en && rb_idx < rb_pops.size() && pops == rb_pops[rb_idx]) begin
        want_rb  = 1'b1;
        want_pop = 1'b0;
      end
    end

    report_segment("end of stream");
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // allow 40 cycles per expected instruction
  initial begin
    wait (loaded);
    repeat (40 * n_exp) @(posedge clock);
    $display("Watchdog expired with %0d of %0d expected instructions delivered",
             exp_idx, n_exp);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
  input  logic                       clock,
  input  logic                       rst,
  input  logic                       en,
  output logic [fetch_pkg::xlen-1:0] imem_addr,
  input  logic [63:0]                imem_data,
  input  logic                       get_next_inst,
  input  logic                       rollback_en,
  input  logic [fetch_pkg::xlen-1:0] rollback_pc,
  output fetch_pkg::fb_decoder_out_t fb_decoder_out,
  output logic                       inst_out_valid
);

  logic [fetch_pkg::xlen-1:0] fetch_pc;
  logic [fetch_pkg::xlen-1:0] pred_next_pc;
  fetch_pkg::fetch_pair_t     fetch_pair;
  logic                       fetch_en;           // back-pressure from the buffer

  fetch_pc_gen u_pc_gen (
    .clock        (clock),
    .rst          (rst),
    .en           (en),
    .fetch_en     (fetch_en),
    .pred_next_pc (pred_next_pc),
    .rollback_en  (rollback_en),
    .rollback_pc  (rollback_pc),
    .fetch_pc     (fetch_pc),
    .imem_addr    (imem_addr)
  );

  fetch_predecode u_predecode (
    .fetch_pc     (fetch_pc),
    .imem_data    (imem_data),
    .fetch_pair   (fetch_pair),
    .pred_next_pc (pred_next_pc)
  );

  fetch_buffer u_buffer (
    .clock          (clock),
    .rst            (rst),
    .en             (en),
    .fetch_pair     (fetch_pair),
    .get_next_inst  (get_next_inst),
    .rollback_en    (rollback_en),
    .fb_decoder_out (fb_decoder_out),
    .inst_out_valid (inst_out_valid),
    .fetch_en       (fetch_en)
  );

endmodule

`default_nettype wire

//--- hdl/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
  input  logic                       clock,
  input  logic                       rst,
  input  logic                       en,
  input  fetch_pkg::fetch_pair_t     fetch_pair,
  input  logic                       get_next_inst, // decoder takes both oldest
  input  logic                       rollback_en,
  output fetch_pkg::fb_decoder_out_t fb_decoder_out,
  output logic                       inst_out_valid,
  output logic                       fetch_en        // fetch side may deliver
);

  fetch_pkg::fetch_entry_t [fetch_pkg::num_fb-1:0] fb;
  fetch_pkg::fetch_entry_t [fetch_pkg::num_fb-1:0] fb_next;

  logic [fetch_pkg::fb_idx_w-1:0] head;            // write pointer
  logic [fetch_pkg::fb_idx_w-1:0] tail;            // read pointer
  logic [fetch_pkg::fb_idx_w-1:0] head_plus_one;
  logic [fetch_pkg::fb_idx_w-1:0] tail_plus_one;
  logic [fetch_pkg::fb_idx_w-1:0] head_next;
  logic [fetch_pkg::fb_idx_w-1:0] tail_next;
  logic [fetch_pkg::fb_idx_w-1:0] wr_cnt;

  fetch_pkg::fetch_entry_t wr_first;               // packed into the head slot
  logic                    wr_any;
  logic                    wr_two;
  logic                    room;
  logic                    do_pop;

  assign head_plus_one = head + fetch_pkg::fb_idx_w'(1);
  assign tail_plus_one = tail + fetch_pkg::fb_idx_w'(1);

  assign wr_any   = fetch_pair[0].valid | fetch_pair[1].valid;
  assign wr_two   = fetch_pair[0].valid & fetch_pair[1].valid;
  assign wr_first = fetch_pair[0].valid ? fetch_pair[0] : fetch_pair[1];
  assign wr_cnt   = fetch_pkg::fb_idx_w'(fetch_pair[0].valid) +
                    fetch_pkg::fb_idx_w'(fetch_pair[1].valid);

  // free slots at the head for every valid slot offered
  assign room     = ~wr_any | (~fb[head].valid & (~wr_two | ~fb[head_plus_one].valid));
  assign fetch_en = room & ~rollback_en;

  assign inst_out_valid = fb[tail].valid & fb[tail_plus_one].valid;
  assign do_pop         = get_next_inst & inst_out_valid;

  // two oldest entries, slot 0 is the older one
  always_comb begin
    fb_decoder_out.npc[0]    = fb[tail].npc;
    fb_decoder_out.npc[1]    = fb[tail_plus_one].npc;
    fb_decoder_out.inst[0]   = fb[tail].inst;
    fb_decoder_out.inst[1]   = fb[tail_plus_one].inst;
    fb_decoder_out.target[0] = fb[tail].target;
    fb_decoder_out.target[1] = fb[tail_plus_one].target;
    fb_decoder_out.valid     = inst_out_valid;
  end

  always_comb begin
    fb_next = fb;
    if (fetch_en & wr_any) begin
      fb_next[head] = wr_first;
    end
    if (fetch_en & wr_two) begin
      fb_next[head_plus_one] = fetch_pair[1];
    end
    if (do_pop) begin                              // tail slots never overlap head writes
      fb_next[tail].valid          = 1'b0;
      fb_next[tail_plus_one].valid = 1'b0;
    end
  end

  assign head_next = fetch_en ? head + wr_cnt : head;
  assign tail_next = do_pop ? tail + fetch_pkg::fb_idx_w'(2) : tail;

  always_ff @(posedge clock) begin
    if (rst | rollback_en) begin
      head <= '0;
      tail <= '0;
      for (int i = 0; i < fetch_pkg::num_fb; i++) begin
        fb[i].valid <= 1'b0;                       // flush
      end
    end else if (en) begin
      fb   <= fb_next;
      head <= head_next;
      tail <= tail_next;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_predecode.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_predecode (
  input  logic [fetch_pkg::xlen-1:0] fetch_pc,
  input  logic [63:0]                imem_data,    // low word at the pair address
  output fetch_pkg::fetch_pair_t     fetch_pair,
  output logic [fetch_pkg::xlen-1:0] pred_next_pc
);

  logic [fetch_pkg::xlen-1:0]                      pair_addr;
  fetch_pkg::inst_t [fetch_pkg::num_super-1:0]     word;
  logic [fetch_pkg::num_super-1:0]                 is_uncond;   // br or bsr
  logic [fetch_pkg::num_super-1:0][fetch_pkg::xlen-1:0] disp_ext;

  assign pair_addr = {fetch_pc[fetch_pkg::xlen-1:3], 3'b000};
  assign word[0]   = imem_data[31:0];
  assign word[1]   = imem_data[63:32];

  always_comb begin
    for (int s = 0; s < fetch_pkg::num_super; s++) begin
      is_uncond[s] = (word[s].br.opcode == fetch_pkg::op_br) |
                     (word[s].br.opcode == fetch_pkg::op_bsr);
      // byte offset from the word displacement
      disp_ext[s]  = {{(fetch_pkg::xlen-23){word[s].br.disp[20]}},
                      word[s].br.disp, 2'b00};
    end
  end

  always_comb begin
    for (int s = 0; s < fetch_pkg::num_super; s++) begin
      fetch_pair[s].npc      = pair_addr + fetch_pkg::xlen'(4 * (s + 1));
      fetch_pair[s].inst.gen = word[s].gen;        // word passed on as is
      if (is_uncond[s]) begin
        fetch_pair[s].target = fetch_pair[s].npc + disp_ext[s];
      end else begin
        fetch_pair[s].target = fetch_pair[s].npc;  // conditionals fall through
      end
    end

    fetch_pair[0].valid = ~fetch_pc[2];            // odd-word entry skips slot 0
    fetch_pair[1].valid = ~(fetch_pair[0].valid & is_uncond[0]);
  end

  // predicted pc follows the youngest valid slot
  always_comb begin
    if (fetch_pair[1].valid & is_uncond[1]) begin
      pred_next_pc = fetch_pair[1].target;
    end else if (fetch_pair[0].valid & is_uncond[0]) begin
      pred_next_pc = fetch_pair[0].target;
    end else begin
      pred_next_pc = pair_addr + fetch_pkg::xlen'(8);
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen (
  input  logic                       clock,
  input  logic                       rst,
  input  logic                       en,
  input  logic                       fetch_en,     // buffer can take the pair
  input  logic [fetch_pkg::xlen-1:0] pred_next_pc,
  input  logic                       rollback_en,
  input  logic [fetch_pkg::xlen-1:0] rollback_pc,
  output logic [fetch_pkg::xlen-1:0] fetch_pc,
  output logic [fetch_pkg::xlen-1:0] imem_addr
);

  logic [fetch_pkg::xlen-1:0] redirect_pc;
  logic [fetch_pkg::xlen-1:0] next_pc;
  logic                       advance;

  assign redirect_pc = {rollback_pc[fetch_pkg::xlen-1:2], 2'b00};  // word aligned
  assign advance     = en & fetch_en;

  // rollback wins over a normal advance and ignores en
  always_comb begin
    next_pc = fetch_pc;
    if (rollback_en) begin
      next_pc = redirect_pc;
    end else if (advance) begin
      next_pc = pred_next_pc;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      fetch_pc <= fetch_pkg::reset_pc;
    end else begin
      fetch_pc <= next_pc;                         // holds under back-pressure
    end
  end

  // An odd-word pc still fetches its containing pair; the predecoder
  // drops slot 0 by looking at bit 2 of fetch_pc.
  assign imem_addr = {fetch_pc[fetch_pkg::xlen-1:3], 3'b000};

endmodule

`default_nettype wire

//--- hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam int num_super = 2;                    // fetch and dispatch width
  localparam int num_fb    = 8;                    // buffer depth
  localparam int fb_idx_w  = 3;                    // buffer index width
  localparam int xlen      = 64;                   // pc width
  localparam int ilen      = 32;                   // instruction width

  localparam logic [xlen-1:0] reset_pc = 64'h0;

  localparam logic [5:0] op_br  = 6'h30;           // unconditional branch
  localparam logic [5:0] op_bsr = 6'h34;           // branch to subroutine

  // branch format view of an instruction word
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [20:0] disp;                             // word displacement
  } inst_br_t;

  // generic opcode/operand view
  typedef struct packed {
    logic [5:0]  opcode;
    logic [ilen-7:0] rest;
  } inst_gen_t;

  typedef union packed {
    inst_br_t  br;
    inst_gen_t gen;
  } inst_t;

  typedef struct packed {
    logic [xlen-1:0] npc;                          // address plus 4
    inst_t           inst;
    logic [xlen-1:0] target;                       // predicted next pc
    logic            valid;
  } fetch_entry_t;

  // predecoded pair, slot 0 at the lower address
  typedef fetch_entry_t [num_super-1:0] fetch_pair_t;

  typedef struct packed {
    logic  [num_super-1:0][xlen-1:0] npc;
    inst_t [num_super-1:0]           inst;
    logic  [num_super-1:0][xlen-1:0] target;
    logic                            valid;        // both slots ready
  } fb_decoder_out_t;

endpackage

`default_nettype wire
